/* Makefile */
# Verilator build and run for the spike counting rig

VERILATOR ?= verilator
TOP       ?= spike_rig_tb
FLIST     ?= spike_rig.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST)))
HDRS := $(wildcard rtl/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source, a header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "TESTBENCH PASSED" $(LOG) || { echo "simulation ended without a result"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* rtl/spike_count_pkg.sv */
`include "spike_rig_config.svh"

package spike_count_pkg;

    // spikes summed over one open window
    typedef logic [`SPIKE_COUNT_W-1:0] window_count_t;

    // which window since load or restart
    typedef logic [`SPIKE_INDEX_W-1:0] window_index_t;

    // one report to the host
    typedef struct packed {
        window_count_t count;
        window_index_t index;
    } window_result_t;

endpackage

/* rtl/spike_counter.sv */
`timescale 1ns/10ps

module spike_counter
(
    input  logic                            ep50trig,
    input  logic                            reset_global,
    input  logic                            replay_restart,
    spike_stream_if.sink                    stream,
    output logic                            step,
    input  logic                            window_open,
    input  logic                            window_close,
    output logic                            result_valid,
    input  logic                            result_ready,
    output spike_count_pkg::window_result_t result
);

    // running sum for the open window
    spike_count_pkg::window_count_t acc;
    spike_count_pkg::window_count_t mask_cnt;
    spike_count_pkg::window_count_t acc_next;
    spike_count_pkg::window_index_t win_idx;

    // number of channels that fired in one element
    function automatic spike_count_pkg::window_count_t popcount
    (
        input spike_wave_pkg::spike_mask_t m
    );
        spike_count_pkg::window_count_t n;
        n = '0;
        for (int i = 0; i < $bits(m); i++)
            n = n + spike_count_pkg::window_count_t'(m[i]);
        return n;
    endfunction

    // stall replay while the host owes us a take
    assign stream.ready = !result_valid;
    assign step         = stream.valid && stream.ready;
    assign mask_cnt     = popcount(stream.mask);
    assign acc_next     = acc + mask_cnt;

    //////////////////////////////////////////////////////////////////////
    // accumulate and close
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            acc          <= '0;
            win_idx      <= '0;
            result_valid <= 1'b0;
        end
        else
        begin
            if (result_valid && result_ready)
                result_valid <= 1'b0;

            if (replay_restart)
            begin
                acc     <= '0;
                win_idx <= '0;
            end
            else if (step && window_close)
            begin
                // closing step counts too
                result_valid <= 1'b1;
                acc          <= '0;
                win_idx      <= win_idx + 1'b1;
            end
            else if (step && stream.last)
                // block over mid window, drop the partial sum
                acc <= '0;
            else if (step && window_open)
                acc <= acc_next;
        end
    end

    // held report, only loaded on a close
    always_ff @(posedge ep50trig)
    begin
        if (!replay_restart && step && window_close)
        begin
            result.count <= acc_next;
            result.index <= win_idx;
        end
    end

endmodule

/* rtl/spike_rig_config.svh */
`ifndef SPIKE_RIG_CONFIG_SVH
`define SPIKE_RIG_CONFIG_SVH

//////////////////////////////////////////////////////////////////////
// rig sizing
//////////////////////////////////////////////////////////////////////

// host word and replay element width
`define SPIKE_WORD_W 16

// waveform memory address bits, 256 elements
`define SPIKE_DEPTH_LOG2 8

// spike total per window
`define SPIKE_COUNT_W 32

// half period of the gating window, in steps
`define SPIKE_HALF_W 18

// window sequence number
`define SPIKE_INDEX_W 16

`endif

/* rtl/spike_rig_top.sv */
`timescale 1ns/10ps
`include "spike_rig_config.svh"

module spike_rig_top
(
    input  logic                      ep50trig,
    input  logic                      reset_global,
    // host load pipe
    input  logic                      load_valid,
    output logic                      load_ready,
    input  logic [`SPIKE_WORD_W-1:0]  load_word,
    input  logic                      replay_restart,
    // gate half period, static during a run
    input  logic [`SPIKE_HALF_W-1:0]  half_cnt,
    // window reports
    output logic                      result_valid,
    input  logic                      result_ready,
    output logic [`SPIKE_COUNT_W-1:0] result_count,
    output logic [`SPIKE_INDEX_W-1:0] result_index
);

    logic                            step;
    logic                            window_open;
    logic                            window_close;
    spike_count_pkg::window_result_t result;

    spike_stream_if replay_if ();

    //////////////////////////////////////////////////////////////////////
    // store and gate side by side, counter joins them
    //////////////////////////////////////////////////////////////////////

    waveform_store store_i (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .load_valid     (load_valid),
        .load_ready     (load_ready),
        .load_word      (spike_wave_pkg::host_word_u'(load_word)),
        .replay_restart (replay_restart),
        .stream         (replay_if.source)
    );

    window_timer timer_i (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .replay_restart (replay_restart),
        .step           (step),
        .half_cnt       (half_cnt),
        .window_open    (window_open),
        .window_close   (window_close)
    );

    spike_counter counter_i (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .replay_restart (replay_restart),
        .stream         (replay_if.sink),
        .step           (step),
        .window_open    (window_open),
        .window_close   (window_close),
        .result_valid   (result_valid),
        .result_ready   (result_ready),
        .result         (result)
    );

    // report fields out to the host
    assign result_count = result.count;
    assign result_index = result.index;

endmodule

/* rtl/spike_stream_if.sv */
`timescale 1ns/10ps

interface spike_stream_if;

    // element handshake, one step per valid and ready
    logic                        valid;
    logic                        ready;
    // final element of a non-looping block
    logic                        last;
    spike_wave_pkg::spike_mask_t mask;

    // replay side
    modport source (output valid, output last, output mask, input ready);

    // counting side
    modport sink (input valid, input last, input mask, output ready);

    // checker taps
    modport monitor (input valid, input ready, input last, input mask);

endinterface

/* rtl/spike_wave_pkg.sv */
`include "spike_rig_config.svh"

package spike_wave_pkg;

    // block length field of a header
    typedef logic [11:0] wave_len_t;

    // first word of a block
    typedef struct packed {
        logic      loop;
        logic [2:0] reserved;
        wave_len_t length;
    } wave_header_t;

    // one bit per channel, set on a spike
    typedef logic [`SPIKE_WORD_W-1:0] spike_mask_t;

    //////////////////////////////////////////////////////////////////////
    // host word, seen two ways
    //////////////////////////////////////////////////////////////////////

    // header for the block's first word
    // mask for every word after it
    typedef union packed {
        wave_header_t header;
        spike_mask_t  mask;
    } host_word_u;

endpackage

/* rtl/waveform_store.sv */
`timescale 1ns/10ps
`include "spike_rig_config.svh"

module waveform_store
(
    input  logic                       ep50trig,
    input  logic                       reset_global,
    input  logic                       load_valid,
    output logic                       load_ready,
    input  spike_wave_pkg::host_word_u load_word,
    input  logic                       replay_restart,
    spike_stream_if.source             stream
);

    typedef enum logic {ST_LOAD, ST_PLAY} store_state_t;

    store_state_t                state;
    // header of the current block already taken
    logic                        got_header;
    logic                        loop_q;
    spike_wave_pkg::wave_len_t   len_q;
    spike_wave_pkg::wave_len_t   len_last;
    // write and replay positions
    spike_wave_pkg::wave_len_t   wr_cnt;
    spike_wave_pkg::wave_len_t   rd_cnt;
    logic                        load_fire;
    logic                        step_fire;
    logic                        at_end;
    spike_wave_pkg::spike_mask_t mem [0:(1 << `SPIKE_DEPTH_LOG2) - 1];

    assign load_ready = (state == ST_LOAD);
    assign load_fire  = load_valid && load_ready;
    assign step_fire  = stream.valid && stream.ready;
    assign len_last   = len_q - spike_wave_pkg::wave_len_t'(1);
    assign at_end     = (rd_cnt == len_last);

    // element under the read pointer, stable while rd_cnt holds
    assign stream.mask = mem[rd_cnt[`SPIKE_DEPTH_LOG2-1:0]];
    assign stream.last = stream.valid && !loop_q && at_end;

    //////////////////////////////////////////////////////////////////////
    // load, then replay
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            state        <= ST_LOAD;
            got_header   <= 1'b0;
            loop_q       <= 1'b0;
            len_q        <= '0;
            wr_cnt       <= '0;
            rd_cnt       <= '0;
            stream.valid <= 1'b0;
        end
        else
        begin
            case (state)
                ST_LOAD:
                begin
                    if (load_fire && !got_header)
                    begin
                        // zero length header is dropped, still waiting
                        if (load_word.header.length != '0)
                        begin
                            got_header <= 1'b1;
                            len_q      <= load_word.header.length;
                            loop_q     <= load_word.header.loop;
                            wr_cnt     <= '0;
                        end
                    end
                    else if (load_fire)
                    begin
                        wr_cnt <= wr_cnt + 1'b1;
                        // last mask in, start replay next cycle
                        if (wr_cnt == len_last)
                        begin
                            state        <= ST_PLAY;
                            rd_cnt       <= '0;
                            stream.valid <= 1'b1;
                        end
                    end
                end
                ST_PLAY:
                begin
                    // restart wins over a step, block is kept
                    if (replay_restart)
                    begin
                        rd_cnt       <= '0;
                        stream.valid <= 1'b1;
                    end
                    else if (step_fire)
                    begin
                        if (at_end && loop_q)
                            rd_cnt <= '0;
                        else if (at_end)
                            stream.valid <= 1'b0;
                        else
                            rd_cnt <= rd_cnt + 1'b1;
                    end
                end
                default:
                    state <= ST_LOAD;
            endcase
        end
    end

    // mask words after the header, long blocks wrap the address
    always_ff @(posedge ep50trig)
    begin
        if (load_fire && got_header)
            mem[wr_cnt[`SPIKE_DEPTH_LOG2-1:0]] <= load_word.mask;
    end

endmodule

/* rtl/window_timer.sv */
`timescale 1ns/10ps
`include "spike_rig_config.svh"

module window_timer
(
    input  logic                     ep50trig,
    input  logic                     reset_global,
    input  logic                     replay_restart,
    input  logic                     step,
    input  logic [`SPIKE_HALF_W-1:0] half_cnt,
    output logic                     window_open,
    output logic                     window_close
);

    localparam int HALF_W = `SPIKE_HALF_W;

    // steps taken in the current half period
    logic [HALF_W-1:0] step_cnt;
    logic [HALF_W-1:0] half_last;
    // high during the open half
    logic              phase_open;
    logic              half_done;

    assign half_last = half_cnt - HALF_W'(1);
    assign half_done = (step_cnt == half_last);

    // both describe the step now on the stream
    assign window_open  = phase_open;
    assign window_close = phase_open && half_done;

    //////////////////////////////////////////////////////////////////////
    // slow gate from step count
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || replay_restart)
        begin
            // first step after load or restart is open
            step_cnt   <= '0;
            phase_open <= 1'b1;
        end
        else if (step && half_done)
        begin
            step_cnt   <= '0;
            phase_open <= !phase_open;
        end
        else if (step)
            step_cnt <= step_cnt + 1'b1;
    end

endmodule

/* spike_rig.f */
+incdir+rtl
rtl/spike_wave_pkg.sv
rtl/spike_count_pkg.sv
rtl/spike_stream_if.sv
rtl/waveform_store.sv
rtl/window_timer.sv
rtl/spike_counter.sv
rtl/spike_rig_top.sv
verif/spike_rig_chk.sv
verif/spike_rig_tb.sv

/* verif/spike_rig_chk.sv */
`timescale 1ns/10ps

module spike_rig_chk
(
    input logic                            ep50trig,
    input logic                            reset_global,
    input logic                            result_valid,
    input logic                            result_ready,
    input logic                            stream_ready,
    input spike_count_pkg::window_result_t result
);

    //////////////////////////////////////////////////////////////////////
    // report handshake rules
    //////////////////////////////////////////////////////////////////////

    // pending report frozen until the host takes it
    property result_held;
        @(posedge ep50trig) disable iff (reset_global)
            (result_valid && !result_ready) |=> $stable(result);
    endproperty

    // replay stalls behind a pending report
    property ready_blocked;
        @(posedge ep50trig) disable iff (reset_global)
            result_valid |-> !stream_ready;
    endproperty

    // nothing to report straight out of reset
    property quiet_after_reset;
        @(posedge ep50trig)
            reset_global |=> !result_valid;
    endproperty

    result_held_a : assert property (result_held)
        else $error("window result changed while still pending");
    ready_blocked_a : assert property (ready_blocked)
        else $error("replay ready high while a result is pending");
    quiet_after_reset_a : assert property (quiet_after_reset)
        else $error("result_valid high right after reset");

endmodule

bind spike_counter spike_rig_chk chk_i (
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .result_valid (result_valid),
    .result_ready (result_ready),
    .stream_ready (stream.ready),
    .result       (result)
);

/* verif/spike_rig_tb.sv */
`timescale 1ns/10ps
`include "spike_rig_config.svh"

module spike_rig_tb;

    localparam int HALF_W = `SPIKE_HALF_W;
    localparam int DEPTH  = 1 << `SPIKE_DEPTH_LOG2;
    localparam int N_ROWS = 6;

    // one test case
    typedef struct {
        bit          loop;
        int          length;
        int          half;
        // results to take where 0 means every full window of a one-shot block
        int          results;
        // results taken before the restart pulse or 0 for none
        int          restart_at;
        bit          rand_fill;
        // keep the masks of the row before
        bit          same_block;
        logic [15:0] fixed_mask;
        bit          rand_ready;
    } row_t;

    logic                      ep50trig;
    logic                      reset_global;
    logic                      load_valid;
    logic                      load_ready;
    logic [`SPIKE_WORD_W-1:0]  load_word;
    logic                      replay_restart;
    logic [`SPIKE_HALF_W-1:0]  half_cnt;
    logic                      result_valid;
    logic                      result_ready;
    logic [`SPIKE_COUNT_W-1:0] result_count;
    logic [`SPIKE_INDEX_W-1:0] result_index;

    row_t        rows [0:N_ROWS-1];
    // block as the host sends it
    logic [15:0] masks [0:DEPTH-1];
    logic [31:0] lfsr_state;
    int          cycles = 0;
    int          cycle_limit = 0;
    int          err_count = 0;

    spike_rig_top dut_i (
        .ep50trig       (ep50trig),
        .reset_global   (reset_global),
        .load_valid     (load_valid),
        .load_ready     (load_ready),
        .load_word      (load_word),
        .replay_restart (replay_restart),
        .half_cnt       (half_cnt),
        .result_valid   (result_valid),
        .result_ready   (result_ready),
        .result_count   (result_count),
        .result_index   (result_index)
    );

    // 10 ns clock
    initial
    begin
        ep50trig = 1'b0;
        forever #5 ep50trig = ~ep50trig;
    end

    // watchdog with its limit set from the table at time 0
    always @(posedge ep50trig)
    begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit)
        begin
            $display("timeout: run still going after %0d clock cycles", cycles);
            $display("TESTBENCH FAILED");
            $fatal(1, "watchdog expired");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // random bits and reference model
    //////////////////////////////////////////////////////////////////////

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    // one shift per bit taken
    function automatic logic [15:0] draw_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // set bits with the lowest one cleared per pass
    function automatic int ones(input logic [15:0] m);
        int          n;
        logic [15:0] v;
        n = 0;
        v = m;
        while (v != 16'h0)
        begin
            v = v & (v - 16'h1);
            n++;
        end
        return n;
    endfunction

    // window w opens at step 2*w*half for half steps and the block wraps
    function automatic spike_count_pkg::window_count_t model_count
    (
        input int len,
        input int half,
        input int w
    );
        int s;
        int total;
        total = 0;
        for (s = 2 * w * half; s < 2 * w * half + half; s++)
            total += ones(masks[s % len]);
        return spike_count_pkg::window_count_t'(total);
    endfunction

    // windows that close inside a one-shot block
    function automatic int full_windows(input int len, input int half);
        int w;
        w = 0;
        while (2 * w * half + half <= len)
            w++;
        return w;
    endfunction

    function automatic int results_for_row(input row_t r);
        return r.loop ? r.results : full_windows(r.length, r.half);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////////////////////////

    task automatic report_fail(input string msg);
        err_count++;
        $display("Fail at %0d ns: %s", $time, msg);
        $display("TESTBENCH FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_count
    (
        input spike_count_pkg::window_count_t got,
        input spike_count_pkg::window_count_t exp
    );
        if (got !== exp)
            report_fail($sformatf("result_count %0d, expected %0d", got, exp));
    endtask

    task automatic check_index
    (
        input spike_count_pkg::window_index_t got,
        input spike_count_pkg::window_index_t exp
    );
        if (got !== exp)
            report_fail($sformatf("result_index %0d, expected %0d", got, exp));
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_fail($sformatf("%s is %b, expected %b", name, got, exp));
    endtask

    //////////////////////////////////////////////////////////////////////
    // drivers move inputs 1 ns after the edge
    //////////////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge ep50trig);
        #1;
    endtask

    task automatic apply_reset(input int half);
        reset_global   = 1'b1;
        load_valid     = 1'b0;
        replay_restart = 1'b0;
        result_ready   = 1'b0;
        // static for the whole row
        half_cnt       = HALF_W'(half);
        repeat (2) next_cycle();
        reset_global = 1'b0;
        check_flag("result_valid after reset", result_valid, 1'b0);
        check_flag("load_ready after reset", load_ready, 1'b1);
    endtask

    task automatic fill_masks(input row_t r);
        int i;
        int k;
        for (i = 0; i < r.length; i++)
        begin
            k = i % 16;
            if (r.rand_fill)
                masks[i] = draw_bits(16);
            else
                // fixed pattern rotated along the block
                masks[i] = (r.fixed_mask << k) | (r.fixed_mask >> (16 - k));
        end
    endtask

    task automatic load_block(input row_t r);
        spike_wave_pkg::host_word_u hw;
        int                         i;
        // empty header first and it must be dropped
        hw             = '0;
        hw.header.loop = 1'b1;
        load_word      = hw;
        load_valid     = 1'b1;
        next_cycle();
        check_flag("load_ready after empty header", load_ready, 1'b1);
        hw.header.loop     = r.loop;
        hw.header.reserved = '0;
        hw.header.length   = spike_wave_pkg::wave_len_t'(r.length);
        load_word          = hw;
        next_cycle();
        for (i = 0; i < r.length; i++)
        begin
            check_flag("load_ready during load", load_ready, 1'b1);
            hw.mask   = masks[i];
            load_word = hw;
            next_cycle();
        end
        load_valid = 1'b0;
        check_flag("load_ready after last mask", load_ready, 1'b0);
    endtask

    // waits for one report and lets a restart ride on its take
    task automatic collect_result
    (
        input row_t r,
        input int   w,
        input bit   do_restart
    );
        spike_count_pkg::window_count_t exp_cnt;
        logic [15:0]                    bits;
        bit                             took;
        exp_cnt = model_count(r.length, r.half, w);
        took    = 1'b0;
        while (!took)
        begin
            bits         = r.rand_ready ? draw_bits(1) : 16'h1;
            result_ready = bits[0];
            if (result_valid && result_ready)
            begin
                check_count(result_count, exp_cnt);
                check_index(result_index, spike_count_pkg::window_index_t'(w));
                replay_restart = do_restart;
                took           = 1'b1;
            end
            next_cycle();
            result_ready   = 1'b0;
            replay_restart = 1'b0;
        end
    endtask

    // one-shot block done so the partial tail must stay silent
    task automatic watch_quiet(input int n);
        result_ready = 1'b1;
        repeat (n)
        begin
            check_flag("result_valid after block end", result_valid, 1'b0);
            next_cycle();
        end
        result_ready = 1'b0;
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus table and main loop
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        int r;
        int i;
        int n;
        int w;
        int limit;
        reset_global   = 1'b1;
        load_valid     = 1'b0;
        load_word      = '0;
        replay_restart = 1'b0;
        half_cnt       = HALF_W'(1);
        result_ready   = 1'b0;
        lfsr_state     = 32'h1600;

        // loop len half results restart rand same fixed rand_ready
        rows[0] = '{1'b1, 10, 3, 5, 0, 1'b0, 1'b0, 16'h00f1, 1'b0};
        // one-shot block with an open tail at steps 24 and 25
        rows[1] = '{1'b0, 26, 3, 0, 0, 1'b1, 1'b0, 16'h0000, 1'b0};
        rows[2] = '{1'b1, 37, 4, 6, 0, 1'b1, 1'b0, 16'h0000, 1'b1};
        // longer window over the row 2 block
        rows[3] = '{1'b1, 37, 9, 4, 0, 1'b0, 1'b1, 16'h0000, 1'b1};
        // restart after window 2 on a block the 4-step period does not divide
        rows[4] = '{1'b1, 13, 2, 6, 3, 1'b1, 1'b0, 16'h0000, 1'b1};
        // one-shot block whose last element closes a window
        rows[5] = '{1'b0, 9, 1, 0, 0, 1'b1, 1'b0, 16'h0000, 1'b1};

        limit = 0;
        for (r = 0; r < N_ROWS; r++)
            limit += (rows[r].length + 2 * rows[r].half * results_for_row(rows[r])) * 4;
        cycle_limit = limit + 200;

        for (r = 0; r < N_ROWS; r++)
        begin
            apply_reset(rows[r].half);
            if (!rows[r].same_block)
                fill_masks(rows[r]);
            load_block(rows[r]);
            n = results_for_row(rows[r]);
            for (i = 0; i < n; i++)
            begin
                // window numbers start over after the restart
                if (rows[r].restart_at > 0 && i >= rows[r].restart_at)
                    w = i - rows[r].restart_at;
                else
                    w = i;
                collect_result(rows[r], w, i + 1 == rows[r].restart_at);
            end
            if (!rows[r].loop)
                watch_quiet(2 * rows[r].length + 4);
        end

        if (err_count == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule
